//--- Makefile
# Verilator simulation of the re-order buffer testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module rob_tb -Mdir obj_dir -f tb.f

run: compile
	./obj_dir/Vrob_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF '** PASS **' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- common/rob_config.svh
// Re-order buffer configuration
// Buffer depth and register-file sizes shared by the RTL

`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Number of buffer entries, kept a power of two so indices wrap
`define ROB_SIZE 8

// Bits of an entry index
`define ROB_INDEX_BITS 3

// Architectural integer registers
`define ARF_SIZE 32

// Bits of an architectural register number
`define ARF_INDEX_BITS 5

// Physical integer registers
`define PRF_SIZE 64

// Bits of a physical register number
`define PRF_INDEX_BITS 6

`endif

//--- common/rob_pkg.sv
// Re-order buffer types
// Vector typedefs for entry indices, register numbers and recovery masks

`default_nettype none

`include "rob_config.svh"

package rob_pkg;

  // Entry index into the circular buffer
  typedef logic [`ROB_INDEX_BITS-1:0] rob_index_t;

  // Occupancy, one bit wider so a full buffer is representable
  typedef logic [`ROB_INDEX_BITS:0] rob_count_t;

  // Architectural register number
  typedef logic [`ARF_INDEX_BITS-1:0] arf_index_t;

  // Physical register number
  typedef logic [`PRF_INDEX_BITS-1:0] prf_index_t;

  // One bit per architectural register
  typedef logic [`ARF_SIZE-1:0] arf_mask_t;

  // One bit per physical register
  typedef logic [`PRF_SIZE-1:0] prf_mask_t;

endpackage

`default_nettype wire

//--- rob/rob_dispatch.sv
// Re-order buffer dispatch side
// Accepts one renamed micro-op per cycle, hands out the tail index
// and forwards the fields to entry storage when there is room

`default_nettype none

`include "rob_config.svh"

module rob_dispatch
  import rob_pkg::*;
(
  input  wire             clock,
  input  wire             reset,

  // From rename
  input  wire             dispatch_valid,
  input  wire arf_index_t dispatch_rd,
  input  wire prf_index_t dispatch_pd,
  input  wire prf_index_t dispatch_pd_prev,
  input  wire             dispatch_branch,

  // From entry storage
  input  wire rob_index_t tail,
  input  wire rob_count_t count,

  // To rename
  output rob_index_t      dispatch_index,
  output logic            allocatable,

  // To entry storage
  output logic            write,
  output rob_index_t      write_index,
  output arf_index_t      write_rd,
  output prf_index_t      write_pd,
  output prf_index_t      write_pd_prev,
  output logic            write_branch
);

  // Room left as long as the occupancy is below the depth
  assign allocatable = (count < rob_count_t'(`ROB_SIZE));

  // New micro-op always lands at the tail
  assign dispatch_index = tail;
  assign write_index    = tail;

  assign write = dispatch_valid & allocatable;

  assign write_rd      = dispatch_rd;
  assign write_pd      = dispatch_pd;
  assign write_pd_prev = dispatch_pd_prev;
  assign write_branch  = dispatch_branch;

endmodule

`default_nettype wire

//--- rob/rob_entries.sv
// Re-order buffer entry storage
// Circular array with head, tail and occupancy; marks completions,
// pops the head on retire and empties itself on a flush

`default_nettype none

`include "rob_config.svh"

module rob_entries
  import rob_pkg::*;
(
  input  wire             clock,
  input  wire             reset,

  // Write group from dispatch
  input  wire             write,
  input  wire rob_index_t write_index,
  input  wire arf_index_t write_rd,
  input  wire prf_index_t write_pd,
  input  wire prf_index_t write_pd_prev,
  input  wire             write_branch,

  // Completion from execution
  input  wire             complete_valid,
  input  wire rob_index_t complete_index,
  input  wire             complete_mispredict,

  // From retire
  input  wire             pop,
  input  wire             flush,

  output rob_index_t      head,
  output rob_index_t      tail,
  output rob_count_t      count,

  output logic [`ROB_SIZE-1:0]                 entry_valid,
  output logic [`ROB_SIZE-1:0]                 entry_complete,
  output logic [`ROB_SIZE-1:0]                 entry_mispredict,
  output logic [`ROB_SIZE*`ARF_INDEX_BITS-1:0] entry_rd,
  output logic [`ROB_SIZE*`PRF_INDEX_BITS-1:0] entry_pd,

  output arf_index_t      head_rd,
  output prf_index_t      head_pd_prev,
  output logic            head_branch
);

  // Payload per entry
  arf_index_t rd_mem      [`ROB_SIZE];
  prf_index_t pd_mem      [`ROB_SIZE];
  prf_index_t pd_prev_mem [`ROB_SIZE];
  logic       branch_mem  [`ROB_SIZE];

  rob_index_t head_next;

  assign head_next = head + rob_index_t'(1);

  always_ff @(posedge clock) begin
    if (reset) begin
      head             <= '0;
      tail             <= '0;
      count            <= '0;
      entry_valid      <= '0;
      entry_complete   <= '0;
      entry_mispredict <= '0;
    end else if (flush) begin
      // Head is the mispredicted branch, everything behind it is dropped
      head             <= head_next;
      tail             <= head_next;
      count            <= '0;
      entry_valid      <= '0;
      entry_complete   <= '0;
      entry_mispredict <= '0;
    end else begin
      if (write) begin
        entry_valid[write_index]      <= 1'b1;
        entry_complete[write_index]   <= 1'b0;
        entry_mispredict[write_index] <= 1'b0;
        tail                          <= tail + rob_index_t'(1);
      end

      // Completions naming an empty slot are dropped
      if (complete_valid && entry_valid[complete_index]) begin
        entry_complete[complete_index]   <= 1'b1;
        entry_mispredict[complete_index] <= complete_mispredict;
      end

      if (pop) begin
        entry_valid[head]      <= 1'b0;
        entry_complete[head]   <= 1'b0;
        entry_mispredict[head] <= 1'b0;
        head                   <= head_next;
      end

      case ({write, pop})
        2'b10:   count <= count + rob_count_t'(1);
        2'b01:   count <= count - rob_count_t'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      rd_mem[write_index]      <= write_rd;
      pd_mem[write_index]      <= write_pd;
      pd_prev_mem[write_index] <= write_pd_prev;
      branch_mem[write_index]  <= write_branch;
    end
  end

  // Flattened views for the recovery mask logic
  always_comb begin
    for (int i = 0; i < `ROB_SIZE; i++) begin
      entry_rd[i*`ARF_INDEX_BITS +: `ARF_INDEX_BITS] = rd_mem[i];
      entry_pd[i*`PRF_INDEX_BITS +: `PRF_INDEX_BITS] = pd_mem[i];
    end
  end

  assign head_rd      = rd_mem[head];
  assign head_pd_prev = pd_prev_mem[head];
  assign head_branch  = branch_mem[head];

endmodule

`default_nettype wire

//--- rob/rob_retire.sv
// Re-order buffer retire side
// Retires the head in program order and, for a mispredicted branch,
// flushes the buffer and reports the younger registers to roll back

`default_nettype none

`include "rob_config.svh"

module rob_retire
  import rob_pkg::*;
(
  input  wire             clock,
  input  wire             reset,

  // From entry storage
  input  wire rob_index_t head,
  input  wire rob_count_t count,

  input  wire [`ROB_SIZE-1:0]                 entry_valid,
  input  wire [`ROB_SIZE-1:0]                 entry_complete,
  input  wire [`ROB_SIZE-1:0]                 entry_mispredict,
  input  wire [`ROB_SIZE*`ARF_INDEX_BITS-1:0] entry_rd,
  input  wire [`ROB_SIZE*`PRF_INDEX_BITS-1:0] entry_pd,

  input  wire arf_index_t head_rd,
  input  wire prf_index_t head_pd_prev,
  input  wire             head_branch,

  // To entry storage
  output logic            pop,
  output logic            flush,

  // To commit
  output logic            retire_valid,
  output rob_index_t      retire_index,
  output arf_index_t      retire_rd,
  output prf_index_t      retire_pd_prev,

  // To rename
  output logic            recover,
  output arf_mask_t       recover_arf_mask,
  output prf_mask_t       recover_pd_mask
);

  logic      head_ready;
  arf_mask_t arf_mask_next;
  prf_mask_t pd_mask_next;

  assign head_ready = (count != '0) && entry_valid[head] && entry_complete[head];

  // Only a branch can redirect, a stray mispredict bit on other ops is ignored
  assign flush = head_ready && entry_mispredict[head] && head_branch;
  assign pop   = head_ready && !flush;

  // Every valid entry other than the head is younger than the branch
  always_comb begin
    arf_mask_next = '0;
    pd_mask_next  = '0;
    for (int i = 0; i < `ROB_SIZE; i++) begin
      if (entry_valid[i] && (rob_index_t'(i) != head)) begin
        arf_mask_next[entry_rd[i*`ARF_INDEX_BITS +: `ARF_INDEX_BITS]] = 1'b1;
        pd_mask_next[entry_pd[i*`PRF_INDEX_BITS +: `PRF_INDEX_BITS]]  = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
      recover      <= 1'b0;
    end else begin
      retire_valid <= pop;
      recover      <= flush;
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      retire_index   <= head;
      retire_rd      <= head_rd;
      retire_pd_prev <= head_pd_prev;
    end
    if (flush) begin
      recover_arf_mask <= arf_mask_next;
      recover_pd_mask  <= pd_mask_next;
    end
  end

endmodule

`default_nettype wire

//--- sim/rob_assert.sv
// Re-order buffer assertions
// Invariants on the allocate, retire and recover strobes at the top level

`default_nettype none

module rob_assert (
  input wire clock,
  input wire reset,
  input wire dispatch_valid,
  input wire allocatable,
  input wire retire_valid,
  input wire recover
);

  // Set by a recover strobe, cleared once a new micro-op is accepted
  logic after_recover;

  always_ff @(posedge clock) begin
    if (reset) begin
      after_recover <= 1'b0;
    end else if (dispatch_valid && allocatable) begin
      after_recover <= 1'b0;
    end else if (recover) begin
      after_recover <= 1'b1;
    end
  end

  strobes_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(retire_valid && recover))
    else $error("retire_valid and recover high in the same cycle");

  allocatable_after_reset: assert property (
    @(posedge clock) reset |=> allocatable)
    else $error("allocatable low right after reset");

  quiet_after_recover: assert property (
    @(posedge clock) disable iff (reset) after_recover |-> !retire_valid)
    else $error("retire strobe after recover without a new dispatch");

endmodule

bind rob_top rob_assert u_assert (
  .clock          (clock),
  .reset          (reset),
  .dispatch_valid (dispatch_valid),
  .allocatable    (allocatable),
  .retire_valid   (retire_valid),
  .recover        (recover)
);

`default_nettype wire

//--- sim/rob_tb.sv
// Re-order buffer testbench
// Directed and random tests against a queue model of the buffer

`default_nettype none

`include "rob_config.svh"

module rob_tb
  import rob_pkg::*;
();

  // Tests take about 330 cycles after reset
  localparam int CYCLE_LIMIT = 4000;

  typedef struct packed {
    rob_index_t index;
    arf_index_t rd;
    prf_index_t pd;
    prf_index_t pd_prev;
    logic       branch;
    logic       complete;
    logic       mispredict;
  } entry_t;

  logic       clock;
  logic       reset;
  logic       dispatch_valid;
  arf_index_t dispatch_rd;
  prf_index_t dispatch_pd;
  prf_index_t dispatch_pd_prev;
  logic       dispatch_branch;
  logic       complete_valid;
  rob_index_t complete_index;
  logic       complete_mispredict;
  rob_index_t dispatch_index;
  logic       allocatable;
  logic       retire_valid;
  rob_index_t retire_index;
  arf_index_t retire_rd;
  prf_index_t retire_pd_prev;
  logic       recover;
  arf_mask_t  recover_arf_mask;
  prf_mask_t  recover_pd_mask;

  // Model of the buffer contents in program order
  entry_t     model_q[$];
  rob_index_t model_tail;

  // Outputs the model expects after the last edge
  logic       exp_retire_valid;
  rob_index_t exp_retire_index;
  arf_index_t exp_retire_rd;
  prf_index_t exp_retire_pd_prev;
  logic       exp_recover;
  arf_mask_t  exp_arf_mask;
  prf_mask_t  exp_pd_mask;

  arf_mask_t   seen_arf_mask;
  prf_mask_t   seen_pd_mask;
  int          retire_seen;
  int          recover_seen;
  int          errors;
  int          checks;
  int          cycle_count = 0;
  logic [31:0] rng_state;

  rob_top DUT (
    .clock               (clock),
    .reset               (reset),
    .dispatch_valid      (dispatch_valid),
    .dispatch_rd         (dispatch_rd),
    .dispatch_pd         (dispatch_pd),
    .dispatch_pd_prev    (dispatch_pd_prev),
    .dispatch_branch     (dispatch_branch),
    .complete_valid      (complete_valid),
    .complete_index      (complete_index),
    .complete_mispredict (complete_mispredict),
    .dispatch_index      (dispatch_index),
    .allocatable         (allocatable),
    .retire_valid        (retire_valid),
    .retire_index        (retire_index),
    .retire_rd           (retire_rd),
    .retire_pd_prev      (retire_pd_prev),
    .recover             (recover),
    .recover_arf_mask    (recover_arf_mask),
    .recover_pd_mask     (recover_pd_mask)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s at %0t: actual 0x%0h, expected 0x%0h",
               name, $time, actual, expected);
      errors++;
    end
  endtask

  // Advances the model by one clock edge
  task automatic update_model(input logic dv, input arf_index_t rd, input prf_index_t pd,
                              input prf_index_t pd_prev, input logic br, input logic cv,
                              input rob_index_t ci, input logic cm);
    entry_t e;
    logic   ready;
    logic   can_alloc;
    exp_retire_valid = 1'b0;
    exp_recover      = 1'b0;
    ready     = (model_q.size() > 0) && model_q[0].complete;
    can_alloc = (model_q.size() < `ROB_SIZE);
    if (ready && model_q[0].branch && model_q[0].mispredict) begin
      // Everything behind the branch is younger and gets rolled back
      exp_arf_mask = '0;
      exp_pd_mask  = '0;
      for (int i = 1; i < model_q.size(); i++) begin
        exp_arf_mask[model_q[i].rd] = 1'b1;
        exp_pd_mask[model_q[i].pd]  = 1'b1;
      end
      exp_recover = 1'b1;
      model_tail  = model_q[0].index + rob_index_t'(1);
      model_q.delete();
    end else begin
      if (cv) begin
        for (int i = 0; i < model_q.size(); i++) begin
          if (model_q[i].index == ci) begin
            e            = model_q[i];
            e.complete   = 1'b1;
            e.mispredict = cm;
            model_q[i]   = e;
          end
        end
      end
      if (ready) begin
        e                  = model_q.pop_front();
        exp_retire_valid   = 1'b1;
        exp_retire_index   = e.index;
        exp_retire_rd      = e.rd;
        exp_retire_pd_prev = e.pd_prev;
      end
      if (dv && can_alloc) begin
        e = '{index: model_tail, rd: rd, pd: pd, pd_prev: pd_prev, branch: br,
              complete: 1'b0, mispredict: 1'b0};
        model_q.push_back(e);
        model_tail = model_tail + rob_index_t'(1);
      end
    end
  endtask

  task automatic compare_outputs();
    check("retire_valid", 64'(retire_valid), 64'(exp_retire_valid));
    check("recover", 64'(recover), 64'(exp_recover));
    if (exp_retire_valid) begin
      check("retire_index", 64'(retire_index), 64'(exp_retire_index));
      check("retire_rd", 64'(retire_rd), 64'(exp_retire_rd));
      check("retire_pd_prev", 64'(retire_pd_prev), 64'(exp_retire_pd_prev));
    end
    if (exp_recover) begin
      check("recover_arf_mask", 64'(recover_arf_mask), 64'(exp_arf_mask));
      check("recover_pd_mask", 64'(recover_pd_mask), 64'(exp_pd_mask));
    end
    if (retire_valid) retire_seen++;
    if (recover) begin
      recover_seen++;
      seen_arf_mask = recover_arf_mask;
      seen_pd_mask  = recover_pd_mask;
    end
  endtask

  // Starts and ends on a falling edge
  task automatic run_cycle(input logic dv, input arf_index_t rd, input prf_index_t pd,
                           input prf_index_t pd_prev, input logic br, input logic cv,
                           input rob_index_t ci, input logic cm);
    logic can_alloc;
    can_alloc = (model_q.size() < `ROB_SIZE);
    check("allocatable", 64'(allocatable), 64'(can_alloc));
    if (can_alloc) check("dispatch_index", 64'(dispatch_index), 64'(model_tail));
    dispatch_valid      = dv;
    dispatch_rd         = rd;
    dispatch_pd         = pd;
    dispatch_pd_prev    = pd_prev;
    dispatch_branch     = br;
    complete_valid      = cv;
    complete_index      = ci;
    complete_mispredict = cm;
    @(posedge clock);
    update_model(dv, rd, pd, pd_prev, br, cv, ci, cm);
    @(negedge clock);
    dispatch_valid = 1'b0;
    complete_valid = 1'b0;
    compare_outputs();
  endtask

  task automatic idle();
    run_cycle(1'b0, '0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic dispatch_op(input arf_index_t rd, input prf_index_t pd,
                             input prf_index_t pd_prev, input logic br,
                             output rob_index_t index);
    index = model_tail;
    run_cycle(1'b1, rd, pd, pd_prev, br, 1'b0, '0, 1'b0);
  endtask

  task automatic complete_op(input rob_index_t index, input logic mispredict);
    run_cycle(1'b0, '0, '0, '0, 1'b0, 1'b1, index, mispredict);
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic idle_after_reset();
    int start_errors;
    start_errors = errors;
    check("allocatable after reset", 64'(allocatable), 64'd1);
    repeat (10) idle();
    check("retires while idle", 64'(retire_seen), 64'd0);
    check("recovers while idle", 64'(recover_seen), 64'd0);
    report_test("1 reset state", start_errors);
  endtask

  task automatic in_order_retire();
    rob_index_t idx [6];
    int         start_errors;
    int         start_retire;
    start_errors = errors;
    start_retire = retire_seen;
    for (int i = 0; i < 6; i++) begin
      dispatch_op(arf_index_t'(i + 1), prf_index_t'(i + 10), prf_index_t'(i + 40), 1'b0,
                  idx[i]);
    end
    // Reverse order still has to retire oldest first
    for (int i = 5; i >= 0; i--) complete_op(idx[i], 1'b0);
    while (retire_seen < start_retire + 6) idle();
    repeat (3) idle();
    check("retire count", 64'(retire_seen - start_retire), 64'd6);
    report_test("2 in-order retire", start_errors);
  endtask

  task automatic full_buffer();
    rob_index_t idx [8];
    rob_index_t dropped;
    int         start_errors;
    int         start_retire;
    start_errors = errors;
    start_retire = retire_seen;
    for (int i = 0; i < 8; i++) begin
      dispatch_op(arf_index_t'(i + 20), prf_index_t'(i + 30), prf_index_t'(i + 2), 1'b0,
                  idx[i]);
    end
    check("allocatable when full", 64'(allocatable), 64'd0);
    dispatch_op(5'd31, 6'd63, 6'd62, 1'b0, dropped);
    for (int i = 0; i < 8; i++) complete_op(idx[i], 1'b0);
    while (retire_seen < start_retire + 8) idle();
    repeat (3) idle();
    check("retire count", 64'(retire_seen - start_retire), 64'd8);
    check("allocatable after drain", 64'(allocatable), 64'd1);
    report_test("3 full buffer", start_errors);
  endtask

  task automatic mispredict_recovery();
    rob_index_t branch_index;
    rob_index_t next_index;
    rob_index_t young [3];
    int         start_errors;
    int         start_retire;
    int         start_recover;
    start_errors  = errors;
    start_retire  = retire_seen;
    start_recover = recover_seen;
    dispatch_op(5'd7, 6'd20, 6'd50, 1'b1, branch_index);
    for (int i = 0; i < 3; i++) begin
      dispatch_op(arf_index_t'(i + 8), prf_index_t'(i + 21), prf_index_t'(i + 51), 1'b0,
                  young[i]);
    end
    for (int i = 2; i >= 0; i--) complete_op(young[i], 1'b0);
    complete_op(branch_index, 1'b1);
    while (recover_seen == start_recover) idle();
    repeat (4) idle();
    check("recover count", 64'(recover_seen - start_recover), 64'd1);
    check("retire count", 64'(retire_seen - start_retire), 64'd0);
    // Younger ops wrote r8..r10 into p21..p23
    check("recover_arf_mask", 64'(seen_arf_mask), 64'h700);
    check("recover_pd_mask", 64'(seen_pd_mask), 64'he0_0000);
    check("index after recover", 64'(dispatch_index),
          64'(rob_index_t'(branch_index + rob_index_t'(1))));
    dispatch_op(5'd3, 6'd33, 6'd34, 1'b0, next_index);
    complete_op(next_index, 1'b0);
    while (retire_seen == start_retire) idle();
    repeat (2) idle();
    report_test("4 mispredict recovery", start_errors);
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    logic [31:0] fields;
    logic        cv;
    logic        cm;
    rob_index_t  ci;
    int          pick;
    int          start_errors;
    int          start_retire;
    int          start_recover;
    rob_index_t  open_index[$];
    logic        open_branch[$];
    start_errors  = errors;
    start_retire  = retire_seen;
    start_recover = recover_seen;
    for (int op = 0; op < 200; op++) begin
      rng_state = xorshift(rng_state);
      r         = rng_state;
      rng_state = xorshift(rng_state);
      fields    = rng_state;
      open_index.delete();
      open_branch.delete();
      for (int i = 0; i < model_q.size(); i++) begin
        if (!model_q[i].complete) begin
          open_index.push_back(model_q[i].index);
          open_branch.push_back(model_q[i].branch);
        end
      end
      cv = (r[6:5] != 2'd0) && (open_index.size() > 0);
      ci = '0;
      cm = 1'b0;
      if (cv) begin
        pick = int'(r[15:8]) % open_index.size();
        ci   = open_index[pick];
        cm   = open_branch[pick] && (r[19:16] < 4'd4);
      end
      run_cycle(r[1:0] != 2'd0, fields[4:0], fields[10:5], fields[16:11], r[4:2] == 3'd0,
                cv, ci, cm);
    end
    while (model_q.size() != 0) begin
      open_index.delete();
      for (int i = 0; i < model_q.size(); i++) begin
        if (!model_q[i].complete) open_index.push_back(model_q[i].index);
      end
      if (open_index.size() > 0) begin
        complete_op(open_index[0], 1'b0);
      end else begin
        idle();
      end
    end
    repeat (3) idle();
    $display("random run: %0d retires, %0d recovers", retire_seen - start_retire,
             recover_seen - start_recover);
    report_test("5 random traffic", start_errors);
  endtask

  initial begin
    reset               = 1'b1;
    dispatch_valid      = 1'b0;
    dispatch_rd         = '0;
    dispatch_pd         = '0;
    dispatch_pd_prev    = '0;
    dispatch_branch     = 1'b0;
    complete_valid      = 1'b0;
    complete_index      = '0;
    complete_mispredict = 1'b0;
    model_tail          = '0;
    exp_retire_valid    = 1'b0;
    exp_recover         = 1'b0;
    retire_seen         = 0;
    recover_seen        = 0;
    errors              = 0;
    checks              = 0;
    rng_state           = 32'd60041;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    idle_after_reset();
    in_order_retire();
    full_buffer();
    mispredict_recovery();
    random_traffic();

    $display("5 tests run, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/rob_pkg.sv
rob/rob_dispatch.sv
rob/rob_entries.sv
rob/rob_retire.sv
verilog/rob_top.sv
sim/rob_assert.sv
sim/rob_tb.sv

//--- verilog/rob_top.sv
// Re-order buffer top level
// Connects dispatch, entry storage and retire

`default_nettype none

`include "rob_config.svh"

module rob_top
  import rob_pkg::*;
(
  input  wire             clock,
  input  wire             reset,

  input  wire             dispatch_valid,
  input  wire arf_index_t dispatch_rd,
  input  wire prf_index_t dispatch_pd,
  input  wire prf_index_t dispatch_pd_prev,
  input  wire             dispatch_branch,

  input  wire             complete_valid,
  input  wire rob_index_t complete_index,
  input  wire             complete_mispredict,

  output rob_index_t      dispatch_index,
  output logic            allocatable,

  output logic            retire_valid,
  output rob_index_t      retire_index,
  output arf_index_t      retire_rd,
  output prf_index_t      retire_pd_prev,

  output logic            recover,
  output arf_mask_t       recover_arf_mask,
  output prf_mask_t       recover_pd_mask
);

  // Dispatch to entries
  logic       write;
  rob_index_t write_index;
  arf_index_t write_rd;
  prf_index_t write_pd;
  prf_index_t write_pd_prev;
  logic       write_branch;

  // Entries state
  rob_index_t head;
  rob_index_t tail;
  rob_count_t count;

  logic [`ROB_SIZE-1:0]                 entry_valid;
  logic [`ROB_SIZE-1:0]                 entry_complete;
  logic [`ROB_SIZE-1:0]                 entry_mispredict;
  logic [`ROB_SIZE*`ARF_INDEX_BITS-1:0] entry_rd;
  logic [`ROB_SIZE*`PRF_INDEX_BITS-1:0] entry_pd;

  arf_index_t head_rd;
  prf_index_t head_pd_prev;
  logic       head_branch;

  // Retire to entries
  logic pop;
  logic flush;

  rob_dispatch u_dispatch (
    .clock            (clock),
    .reset            (reset),
    .dispatch_valid   (dispatch_valid),
    .dispatch_rd      (dispatch_rd),
    .dispatch_pd      (dispatch_pd),
    .dispatch_pd_prev (dispatch_pd_prev),
    .dispatch_branch  (dispatch_branch),
    .tail             (tail),
    .count            (count),
    .dispatch_index   (dispatch_index),
    .allocatable      (allocatable),
    .write            (write),
    .write_index      (write_index),
    .write_rd         (write_rd),
    .write_pd         (write_pd),
    .write_pd_prev    (write_pd_prev),
    .write_branch     (write_branch)
  );

  rob_entries u_entries (
    .clock               (clock),
    .reset               (reset),
    .write               (write),
    .write_index         (write_index),
    .write_rd            (write_rd),
    .write_pd            (write_pd),
    .write_pd_prev       (write_pd_prev),
    .write_branch        (write_branch),
    .complete_valid      (complete_valid),
    .complete_index      (complete_index),
    .complete_mispredict (complete_mispredict),
    .pop                 (pop),
    .flush               (flush),
    .head                (head),
    .tail                (tail),
    .count               (count),
    .entry_valid         (entry_valid),
    .entry_complete      (entry_complete),
    .entry_mispredict    (entry_mispredict),
    .entry_rd            (entry_rd),
    .entry_pd            (entry_pd),
    .head_rd             (head_rd),
    .head_pd_prev        (head_pd_prev),
    .head_branch         (head_branch)
  );

  rob_retire u_retire (
    .clock            (clock),
    .reset            (reset),
    .head             (head),
    .count            (count),
    .entry_valid      (entry_valid),
    .entry_complete   (entry_complete),
    .entry_mispredict (entry_mispredict),
    .entry_rd         (entry_rd),
    .entry_pd         (entry_pd),
    .head_rd          (head_rd),
    .head_pd_prev     (head_pd_prev),
    .head_branch      (head_branch),
    .pop              (pop),
    .flush            (flush),
    .retire_valid     (retire_valid),
    .retire_index     (retire_index),
    .retire_rd        (retire_rd),
    .retire_pd_prev   (retire_pd_prev),
    .recover          (recover),
    .recover_arf_mask (recover_arf_mask),
    .recover_pd_mask  (recover_pd_mask)
  );

endmodule

`default_nettype wire
